/* meas_pkg.sv */
//======================================================================
// shared definitions of the signal meter
//   widths and vector typedefs for samples, counts and readings
//   window snapshot and formatted result structs
//   formatter state encoding
//   mid level, duty scale and default stage parameters
//======================================================================
package meas_pkg;

    //==================================================================
    // widths
    //==================================================================
    localparam int SAMPLE_W  = 10;  // ADC resolution
    localparam int COUNT_W   = 16;  // per-window counters
    localparam int READING_W = 16;  // one output reading

    typedef logic [SAMPLE_W-1:0]  sample_t;
    typedef logic [COUNT_W-1:0]   count_t;
    typedef logic [READING_W-1:0] reading_t;

    // one finished gate window, 58 bits
    typedef struct packed {
        count_t  crossings;     // rising crossings of mid level
        count_t  high_count;    // samples at or above mid level
        count_t  total_count;   // all samples in the window
        sample_t peak_to_peak;  // max - min, 0 when no samples
    } window_snapshot_t;

    // one formatted result, 49 bits
    typedef struct packed {
        reading_t freq_value;
        logic     freq_is_khz;  // 1 = value is raw crossings
        reading_t amplitude;
        reading_t duty;         // tenths of a percent
    } meter_result_t;

    typedef enum logic [1:0] {
        IDLE,
        DIVIDE,
        PUBLISH
    } fmt_state_t;

    //==================================================================
    // constants and stage defaults
    //==================================================================
    localparam sample_t MID_LEVEL = 10'd512;
    localparam int unsigned DUTY_FULL_SCALE = 1000;  // 100.0 percent

    // keeps every per-window count inside count_t
    localparam int unsigned DEFAULT_GATE_CYCLES   = 50000;
    localparam int unsigned DEFAULT_FREQ_SCALE    = 10;     // crossings to Hz
    localparam int unsigned DEFAULT_KHZ_THRESHOLD = 10000;
    localparam int unsigned DEFAULT_FIFO_DEPTH    = 2;

endpackage

/* window_accumulator.sv */
//======================================================================
// gate window accumulator
//   fixed-length gate timer running while measure_en is high
//   crossing, high, total and peak trackers per window
//   snapshot capture with push or drop at each window end
//======================================================================
`timescale 1ns/100ps

module window_accumulator #(
    parameter int unsigned GATE_CYCLES = meas_pkg::DEFAULT_GATE_CYCLES
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  meas_pkg::sample_t          sample_data,
    input  logic                       sample_valid,
    input  logic                       measure_en,
    input  logic                       full,
    output meas_pkg::window_snapshot_t snap_data,
    output logic                       snap_push,
    output logic                       window_lost
);

    localparam int GATE_W = (GATE_CYCLES > 1) ? $clog2(GATE_CYCLES) : 1;

    logic [GATE_W-1:0]  gate_cnt;
    logic               win_last;     // final cycle of the current window
    logic               win_done;     // one cycle after win_last
    logic               accept;
    logic               is_high;
    logic               is_cross;
    logic               prev_valid;
    logic               prev_high;
    meas_pkg::count_t   crossings;
    meas_pkg::count_t   high_count;
    meas_pkg::count_t   total_count;
    meas_pkg::sample_t  max_val;
    meas_pkg::sample_t  min_val;
    meas_pkg::count_t   cross_next;
    meas_pkg::count_t   high_next;
    meas_pkg::count_t   total_next;
    meas_pkg::sample_t  max_next;
    meas_pkg::sample_t  min_next;

    //==================================================================
    // gate timer
    //==================================================================
    assign win_last = measure_en && (gate_cnt == GATE_W'(GATE_CYCLES - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gate_cnt <= '0;
            win_done <= 1'b0;
        end else begin
            win_done <= win_last;
            if (!measure_en || win_last) begin
                gate_cnt <= '0;
            end else begin
                gate_cnt <= gate_cnt + 1'b1;
            end
        end
    end

    //==================================================================
    // per-sample trackers
    //==================================================================
    assign accept   = measure_en && sample_valid;
    assign is_high  = sample_data >= meas_pkg::MID_LEVEL;
    assign is_cross = accept && is_high && prev_valid && !prev_high;

    // counts including the sample of this cycle
    assign cross_next = crossings + meas_pkg::count_t'(is_cross);
    assign high_next  = high_count + meas_pkg::count_t'(accept && is_high);
    assign total_next = total_count + meas_pkg::count_t'(accept);
    assign max_next   = (accept && sample_data > max_val) ? sample_data : max_val;
    assign min_next   = (accept && sample_data < min_val) ? sample_data : min_val;

    // last level survives window ends, dropped with measure_en
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_valid <= 1'b0;
            prev_high  <= 1'b0;
        end else if (!measure_en) begin
            prev_valid <= 1'b0;
            prev_high  <= 1'b0;
        end else if (accept) begin
            prev_valid <= 1'b1;
            prev_high  <= is_high;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crossings   <= '0;
            high_count  <= '0;
            total_count <= '0;
            max_val     <= '0;
            min_val     <= '1;
        end else if (!measure_en || win_last) begin
            // restart, next window begins on the following cycle
            crossings   <= '0;
            high_count  <= '0;
            total_count <= '0;
            max_val     <= '0;
            min_val     <= '1;
        end else begin
            crossings   <= cross_next;
            high_count  <= high_next;
            total_count <= total_next;
            max_val     <= max_next;
            min_val     <= min_next;
        end
    end

    //==================================================================
    // snapshot capture
    //==================================================================
    always_ff @(posedge clk) begin
        if (win_last) begin
            snap_data.crossings   <= cross_next;
            snap_data.high_count  <= high_next;
            snap_data.total_count <= total_next;
            snap_data.peak_to_peak <= (total_next == '0) ? '0 : max_next - min_next;
        end
    end

    assign snap_push   = win_done && !full;
    assign window_lost = win_done && full;   // window discarded

endmodule

/* snapshot_fifo.sv */
//======================================================================
// snapshot buffer
//   register FIFO of window snapshots between accumulator and formatter
//   head is shown directly from the read pointer
//======================================================================
`timescale 1ns/100ps

module snapshot_fifo #(
    parameter int unsigned FIFO_DEPTH = meas_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push,
    input  meas_pkg::window_snapshot_t push_data,
    input  logic                       pop,
    output meas_pkg::window_snapshot_t head,
    output logic                       full,
    output logic                       empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    meas_pkg::window_snapshot_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign full    = count == CNT_W'(FIFO_DEPTH);
    assign empty   = count == '0;
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* result_formatter.sv */
//======================================================================
// result formatter
//   pops one snapshot at a time from the buffer
//   frequency scaling with Hz/kHz unit selection
//   restoring serial divider for the duty cycle
//   registered result and one-cycle valid pulse
//======================================================================
`timescale 1ns/100ps

module result_formatter #(
    parameter int unsigned FREQ_SCALE    = meas_pkg::DEFAULT_FREQ_SCALE,
    parameter int unsigned KHZ_THRESHOLD = meas_pkg::DEFAULT_KHZ_THRESHOLD
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  meas_pkg::window_snapshot_t head,
    input  logic                       empty,
    output logic                       pop,
    output meas_pkg::meter_result_t    result,
    output logic                       result_valid
);

    localparam int COUNT_W = $bits(meas_pkg::count_t);
    localparam int READ_W  = $bits(meas_pkg::reading_t);
    // high_count * 1000 needs 10 bits on top of a count
    localparam int NUM_W   = COUNT_W + $clog2(meas_pkg::DUTY_FULL_SCALE);
    localparam int BIT_W   = $clog2(NUM_W);

    meas_pkg::fmt_state_t state;
    logic [BIT_W-1:0]     bit_cnt;
    logic [NUM_W-1:0]     num_init;
    logic [NUM_W-1:0]     quo_num;     // numerator shifts out, quotient in
    logic [COUNT_W:0]     rem;
    logic [COUNT_W:0]     rem_shift;
    logic                 sub_ok;
    meas_pkg::count_t     divisor;
    logic [31:0]          freq_full;
    meas_pkg::reading_t   freq_q;
    logic                 khz_q;
    meas_pkg::reading_t   amp_q;

    //==================================================================
    // snapshot intake
    //==================================================================
    assign pop       = (state == meas_pkg::IDLE) && !empty;
    assign freq_full = 32'(head.crossings) * 32'(FREQ_SCALE);
    assign num_init  = NUM_W'(head.high_count) * NUM_W'(meas_pkg::DUTY_FULL_SCALE);

    // one restoring step per cycle
    assign rem_shift = {rem[COUNT_W-1:0], quo_num[NUM_W-1]};
    assign sub_ok    = rem_shift >= {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (pop) begin
            khz_q   <= 32'(head.crossings) >= KHZ_THRESHOLD;
            freq_q  <= (32'(head.crossings) >= KHZ_THRESHOLD) ? head.crossings
                                                              : freq_full[READ_W-1:0];
            amp_q   <= READ_W'(head.peak_to_peak);   // zero-extend
            divisor <= head.total_count;
            quo_num <= num_init;
            rem     <= '0;
        end else if (state == meas_pkg::DIVIDE) begin
            rem     <= sub_ok ? rem_shift - {1'b0, divisor} : rem_shift;
            quo_num <= {quo_num[NUM_W-2:0], sub_ok};
        end
    end

    //==================================================================
    // control FSM
    //==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= meas_pkg::IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                meas_pkg::IDLE: begin
                    bit_cnt <= '0;
                    if (pop) begin
                        state <= meas_pkg::DIVIDE;
                    end
                end
                meas_pkg::DIVIDE: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == BIT_W'(NUM_W - 1)) begin
                        state <= meas_pkg::PUBLISH;
                    end
                end
                default: state <= meas_pkg::IDLE;   // PUBLISH lasts one cycle
            endcase
        end
    end

    //==================================================================
    // output registers
    //==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= state == meas_pkg::PUBLISH;
            if (state == meas_pkg::PUBLISH) begin
                result.freq_value  <= freq_q;
                result.freq_is_khz <= khz_q;
                result.amplitude   <= amp_q;
                // empty window divides by zero
                result.duty <= (divisor == '0) ? '0 : quo_num[READ_W-1:0];
            end
        end
    end

endmodule

/* signal_meter_top.sv */
//======================================================================
// signal meter top level
//   window accumulator -> snapshot FIFO -> result formatter
//   stage parameters set here and passed down
//======================================================================
`timescale 1ns/100ps

module signal_meter_top #(
    parameter int unsigned GATE_CYCLES   = meas_pkg::DEFAULT_GATE_CYCLES,
    parameter int unsigned FIFO_DEPTH    = meas_pkg::DEFAULT_FIFO_DEPTH,
    parameter int unsigned FREQ_SCALE    = meas_pkg::DEFAULT_FREQ_SCALE,
    parameter int unsigned KHZ_THRESHOLD = meas_pkg::DEFAULT_KHZ_THRESHOLD
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  meas_pkg::sample_t       sample_data,
    input  logic                    sample_valid,
    input  logic                    measure_en,
    output meas_pkg::meter_result_t result,
    output logic                    result_valid,
    output logic                    window_lost
);

    meas_pkg::window_snapshot_t snap_data;
    meas_pkg::window_snapshot_t head;
    logic                       snap_push;
    logic                       full;
    logic                       empty;
    logic                       pop;

    window_accumulator #(
        .GATE_CYCLES (GATE_CYCLES)
    ) u_accum (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_data  (sample_data),
        .sample_valid (sample_valid),
        .measure_en   (measure_en),
        .full         (full),
        .snap_data    (snap_data),
        .snap_push    (snap_push),
        .window_lost  (window_lost)
    );

    snapshot_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (snap_push),
        .push_data (snap_data),
        .pop       (pop),
        .head      (head),
        .full      (full),
        .empty     (empty)
    );

    result_formatter #(
        .FREQ_SCALE    (FREQ_SCALE),
        .KHZ_THRESHOLD (KHZ_THRESHOLD)
    ) u_formatter (
        .clk          (clk),
        .rst_n        (rst_n),
        .head         (head),
        .empty        (empty),
        .pop          (pop),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

/* tb_clock_gen.sv */
//======================================================================
// testbench clock and reset
//   free-running clock, reset held low for a number of cycles
//======================================================================
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;   // released away from the active edge
    end

endmodule

/* signal_meter_props.sv */
//======================================================================
// protocol checks of the signal meter
//   single-cycle result pulse, duty range, FIFO push/pop legality
//   fixed formatter latency from pop to result
//   bound into the top level
//======================================================================
`timescale 1ns/100ps

module signal_meter_props (
    input logic                    clk,
    input logic                    rst_n,
    input meas_pkg::meter_result_t result,
    input logic                    result_valid,
    input logic                    snap_push,
    input logic                    full,
    input logic                    pop,
    input logic                    empty,
    input meas_pkg::fmt_state_t    fmt_state
);

    localparam int DIV_CYCLES = 26;   // bits of the high_count * 1000 numerator

    valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |=> !result_valid)
        else $error("result_valid high in two consecutive cycles");

    duty_range: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> result.duty <= meas_pkg::DUTY_FULL_SCALE)
        else $error("duty above full scale");

    push_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(snap_push && full))
        else $error("snapshot pushed into a full FIFO");

    pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !(pop && empty))
        else $error("pop from an empty FIFO");

    // one divider cycle per numerator bit, one publish cycle, then the pulse
    fixed_latency: assert property (@(posedge clk) disable iff (!rst_n)
        pop |=> (fmt_state == meas_pkg::DIVIDE) [*DIV_CYCLES]
            ##1 (fmt_state == meas_pkg::PUBLISH) ##1 result_valid)
        else $error("result not published 28 cycles after pop");

endmodule

bind signal_meter_top signal_meter_props u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .result       (result),
    .result_valid (result_valid),
    .snap_push    (snap_push),
    .full         (full),
    .pop          (pop),
    .empty        (empty),
    .fmt_state    (u_formatter.state)
);

/* signal_meter_tb.sv */
//======================================================================
// signal meter testbench
//   pattern stimulus driven on the falling edge
//   window mirror building expected snapshots, reference result model
//   result comparison, cycle timeout and closing summary
//======================================================================
`timescale 1ns/100ps

module signal_meter_tb;

    localparam int unsigned GATE   = 24;
    localparam int unsigned KHZ_TH = 8;
    localparam int unsigned DEPTH  = 2;
    localparam int unsigned SCALE  = meas_pkg::DEFAULT_FREQ_SCALE;
    localparam int unsigned GAP    = 100;   // idle cycles that let the FIFO drain
    localparam int SQUARE = 0, RANDOM = 1, FAST = 2, SLOW = 3, EMPTY = 4;

    // 33 full windows, 14 cycles of a cut window, 8 gaps
    localparam int unsigned STIM_CYCLES    = 33 * GATE + 14 + 8 * GAP + 10;
    localparam int unsigned TIMEOUT_CYCLES = STIM_CYCLES + 300;

    logic                    clk;
    logic                    rst_n;
    meas_pkg::sample_t       sample_data;
    logic                    sample_valid;
    logic                    measure_en;
    meas_pkg::meter_result_t result;
    logic                    result_valid;
    logic                    window_lost;

    integer seed = 32'h5d39_1506;
    int mismatch_errors = 0;
    int other_errors    = 0;
    int results_seen    = 0;
    int lost_seen       = 0;
    int cycle_count     = 0;
    meas_pkg::window_snapshot_t expected_q [$];

    // mirror of the window rules
    int unsigned m_gate, m_cross, m_high, m_total, m_max, m_min;
    logic        m_prev_valid, m_prev_high;

    tb_clock_gen #(.PERIOD(10), .RESET_CYCLES(5)) u_clk (.clk(clk), .rst_n(rst_n));

    signal_meter_top #(
        .GATE_CYCLES   (GATE),
        .FIFO_DEPTH    (DEPTH),
        .FREQ_SCALE    (SCALE),
        .KHZ_THRESHOLD (KHZ_TH)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_data  (sample_data),
        .sample_valid (sample_valid),
        .measure_en   (measure_en),
        .result       (result),
        .result_valid (result_valid),
        .window_lost  (window_lost)
    );

    //==================================================================
    // reference model
    //==================================================================
    function automatic meas_pkg::meter_result_t expected_result(
        meas_pkg::window_snapshot_t s
    );
        meas_pkg::meter_result_t r;
        longint unsigned         prod;
        r.freq_is_khz = s.crossings >= KHZ_TH;
        prod = s.crossings;
        if (!r.freq_is_khz) begin
            prod = prod * SCALE;
        end
        r.freq_value = meas_pkg::reading_t'(prod);
        r.amplitude  = meas_pkg::reading_t'(s.peak_to_peak);
        prod = s.high_count;
        prod = prod * meas_pkg::DUTY_FULL_SCALE;
        r.duty = (s.total_count == 0) ? '0 : meas_pkg::reading_t'(prod / s.total_count);
        return r;
    endfunction

    task automatic restart_window();
        m_gate  = 0;
        m_cross = 0;
        m_high  = 0;
        m_total = 0;
        m_max   = 0;
        m_min   = 1023;
    endtask

    // inputs were driven half a cycle earlier and are stable here
    always @(posedge clk or negedge rst_n) begin : window_mirror
        logic                       acc;
        logic                       hi;
        meas_pkg::window_snapshot_t snap;
        if (!rst_n) begin
            restart_window();
            m_prev_valid = 1'b0;
            m_prev_high  = 1'b0;
        end else begin
            acc = measure_en && sample_valid;
            hi  = sample_data >= meas_pkg::MID_LEVEL;
            if (acc) begin
                if (hi && m_prev_valid && !m_prev_high) m_cross++;
                if (hi) m_high++;
                m_total++;
                if (sample_data > m_max) m_max = sample_data;
                if (sample_data < m_min) m_min = sample_data;
                m_prev_valid = 1'b1;
                m_prev_high  = hi;
            end
            if (!measure_en) begin
                restart_window();
                m_prev_valid = 1'b0;   // no crossing across a gap
            end else if (m_gate == GATE - 1) begin
                snap.crossings    = meas_pkg::count_t'(m_cross);
                snap.high_count   = meas_pkg::count_t'(m_high);
                snap.total_count  = meas_pkg::count_t'(m_total);
                snap.peak_to_peak = (m_total == 0) ? '0 : meas_pkg::sample_t'(m_max - m_min);
                expected_q.push_back(snap);
                restart_window();
            end else begin
                m_gate++;
            end
        end
    end

    //==================================================================
    // output comparison
    //==================================================================
    task automatic compare_field(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
        assert (got === exp) else begin
            mismatch_errors++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    always @(negedge clk) begin : output_check
        meas_pkg::window_snapshot_t snap;
        meas_pkg::meter_result_t    exp;
        if (rst_n && window_lost) begin
            lost_seen++;
            assert (expected_q.size() > 0) else begin
                other_errors++;
                $display("window_lost pulsed with no finished window pending");
            end
            // the dropped window is the newest one
            if (expected_q.size() > 0) expected_q.delete(expected_q.size() - 1);
        end
        if (rst_n && result_valid) begin
            results_seen++;
            assert (expected_q.size() > 0) else begin
                other_errors++;
                $display("result_valid pulsed with no finished window pending");
            end
            if (expected_q.size() > 0) begin
                snap = expected_q.pop_front();
                exp  = expected_result(snap);
                compare_field("freq_value", result.freq_value, exp.freq_value);
                compare_field("freq_is_khz", 16'(result.freq_is_khz), 16'(exp.freq_is_khz));
                compare_field("amplitude", result.amplitude, exp.amplitude);
                compare_field("duty", result.duty, exp.duty);
            end
        end
    end

    //==================================================================
    // stimulus
    //==================================================================
    task automatic drive(input logic en, input logic valid, input meas_pkg::sample_t data);
        @(negedge clk);
        measure_en   = en;
        sample_valid = valid;
        sample_data  = data;
    endtask

    task automatic run_pattern(input int cycles, input int kind);
        logic              valid;
        meas_pkg::sample_t data;
        for (int i = 0; i < cycles; i++) begin
            case (kind)
                SQUARE: drive(1'b1, 1'b1, (i % 8 < 4) ? 10'd700 : 10'd300);
                RANDOM: begin
                    valid = $random(seed);
                    data  = $random(seed);
                    drive(1'b1, valid, data);
                end
                FAST:   drive(1'b1, 1'b1, (i % 2 == 1) ? 10'd1023 : 10'd0);
                SLOW:   drive(1'b1, 1'b1, (i % 16 < 8) ? 10'd600 : 10'd400);
                default: drive(1'b1, 1'b0, '0);   // no strobes at all
            endcase
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) drive(1'b0, 1'b0, '0);
    endtask

    initial begin : stimulus
        measure_en   = 1'b0;
        sample_valid = 1'b0;
        sample_data  = '0;
        wait (rst_n === 1'b1);
        @(negedge clk);
        assert (result == '0 && !result_valid && !window_lost) else begin
            other_errors++;
            $display("outputs not cleared after reset");
        end
        run_pattern(3 * GATE, SQUARE);
        idle(GAP);
        run_pattern(6 * GATE, RANDOM);
        idle(GAP);
        run_pattern(2 * GATE, FAST);        // unit flag set
        idle(GAP);
        run_pattern(2 * GATE, SLOW);        // unit flag clear
        idle(GAP);
        run_pattern(2 * GATE, EMPTY);
        idle(GAP);
        run_pattern(16 * GATE, SQUARE);     // continuous windows overrun the FIFO
        idle(GAP);
        run_pattern(GATE + 14, SQUARE);     // cut while low
        idle(GAP);
        run_pattern(GATE, SLOW);            // starts high after the gap
        idle(GAP);
        assert (expected_q.size() == 0) else begin
            other_errors++;
            $display("%0d finished windows never produced a result", expected_q.size());
        end
        assert (lost_seen > 0) else begin
            other_errors++;
            $display("no window_lost pulse seen under back-pressure");
        end
        $display("errors: %0d mismatches, %0d other; %0d results, %0d windows lost",
                 mismatch_errors, other_errors, results_seen, lost_seen);
        if (mismatch_errors + other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin : timeout_guard
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, stimulus did not complete", cycle_count);
        $display("errors: %0d mismatches, %0d other; %0d results, %0d windows lost",
                 mismatch_errors, other_errors, results_seen, lost_seen);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* signal_meter_top.f */
meas_pkg.sv
window_accumulator.sv
snapshot_fifo.sv
result_formatter.sv
signal_meter_top.sv
tb_clock_gen.sv
signal_meter_props.sv
signal_meter_tb.sv

/* Bender.yml */
package:
  name: signal_meter

sources:
  - meas_pkg.sv
  - window_accumulator.sv
  - snapshot_fifo.sv
  - result_formatter.sv
  - signal_meter_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - signal_meter_props.sv
      - signal_meter_tb.sv
